/* mipsDefines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Machine word and register index
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// Data RAM depth as a word address, 1024 words
`define DMEM_ADDR_WIDTH 10

// Link destination for jal
`define LINK_REG 5'd31

// Sequential fetch step
`define PC_STEP 32'd4

// Return address sits past the delay slot
`define LINK_OFFSET 32'd8

`endif

/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

   // Primary opcode in instr[31:26]
   typedef enum logic [5:0] {
      opSpecial = 6'h00,
      opJ       = 6'h02,
      opJal     = 6'h03,
      opBeq     = 6'h04,
      opBne     = 6'h05,
      opBlez    = 6'h06,
      opBgtz    = 6'h07,
      opAddiu   = 6'h09,
      opSlti    = 6'h0a,
      opSltiu   = 6'h0b,
      opAndi    = 6'h0c,
      opOri     = 6'h0d,
      opXori    = 6'h0e,
      opLui     = 6'h0f,
      opLb      = 6'h20,
      opLh      = 6'h21,
      opLw      = 6'h23,
      opLbu     = 6'h24,
      opLhu     = 6'h25,
      opSb      = 6'h28,
      opSh      = 6'h29,
      opSw      = 6'h2b
   } opcodeT;

   // Function field of special instructions, instr[5:0]
   typedef enum logic [5:0] {
      fnJr   = 6'h08,
      fnJalr = 6'h09,
      fnAddu = 6'h21,
      fnSubu = 6'h23,
      fnAnd  = 6'h24,
      fnOr   = 6'h25,
      fnXor  = 6'h26,
      fnNor  = 6'h27,
      fnSlt  = 6'h2a,
      fnSltu = 6'h2b
   } functT;

   // ALU operation select
   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu, aluLui
   } aluOpT;

endpackage

`default_nettype wire

/* controlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
   import mipsPkg::*;
(
   input  opcodeT opcode,
   input  functT  funct,
   output logic   memToReg,
   output logic   regWrite,
   // Low for sign extension, high for zero extension
   output logic   extType,
   output logic   aluSrc,
   output logic   regDst,
   output aluOpT  aluOp,
   output logic   jump,
   output logic   jr,
   output logic   jal,
   output logic   jalr
);

   always_comb begin
      // Defaults describe a bubble
      memToReg = 1'b0;
      regWrite = 1'b0;
      extType  = 1'b0;
      aluSrc   = 1'b0;
      regDst   = 1'b0;
      aluOp    = aluAdd;
      jump     = 1'b0;
      jr       = 1'b0;
      jal      = 1'b0;
      jalr     = 1'b0;
      case (opcode)
         opSpecial: begin
            regDst = 1'b1;
            // Nop and unknown functions fall through without a write
            regWrite = funct inside {fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                                     fnSlt, fnSltu, fnJalr};
            case (funct)
               fnSubu:  aluOp = aluSub;
               fnAnd:   aluOp = aluAnd;
               fnOr:    aluOp = aluOr;
               fnXor:   aluOp = aluXor;
               fnNor:   aluOp = aluNor;
               fnSlt:   aluOp = aluSlt;
               fnSltu:  aluOp = aluSltu;
               fnJr:    jr = 1'b1;
               fnJalr:  jalr = 1'b1;
               default: aluOp = aluAdd;
            endcase
         end
         opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
            // Logical immediates zero extend
            extType  = opcode inside {opAndi, opOri, opXori};
            case (opcode)
               opSlti:  aluOp = aluSlt;
               opSltiu: aluOp = aluSltu;
               opAndi:  aluOp = aluAnd;
               opOri:   aluOp = aluOr;
               opXori:  aluOp = aluXor;
               opLui:   aluOp = aluLui;
               default: aluOp = aluAdd;
            endcase
         end
         opLb, opLh, opLw, opLbu, opLhu: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
            memToReg = 1'b1;
         end
         // Address is base plus sign-extended offset
         opSb, opSh, opSw: aluSrc = 1'b1;
         opJ: jump = 1'b1;
         opJal: begin
            jump     = 1'b1;
            jal      = 1'b1;
            regWrite = 1'b1;
         end
         // Branches only need the sign-extended offset
         default: aluOp = aluAdd;
      endcase
   end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsDefines.svh"

module regFile
   import mipsPkg::*;
(
   input  logic                       clk,
   input  logic [`REG_ADDR_WIDTH-1:0] ra1,
   input  logic [`REG_ADDR_WIDTH-1:0] ra2,
   input  logic                       we,
   input  logic [`REG_ADDR_WIDTH-1:0] wa,
   input  logic [`DATA_WIDTH-1:0]     wd,
   output logic [`DATA_WIDTH-1:0]     rd1,
   output logic [`DATA_WIDTH-1:0]     rd2
);

   // Register 0 has no storage
   logic [`DATA_WIDTH-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (we && (wa != '0)) begin
         regs[wa] <= wd;
      end
   end

   // Register 0 reads as zero
   // Write-through bypass lets decode see the value written this cycle
   assign rd1 = (ra1 == '0) ? '0 : ((we && (wa == ra1)) ? wd : regs[ra1]);
   assign rd2 = (ra2 == '0) ? '0 : ((we && (wa == ra2)) ? wd : regs[ra2]);

   // Write address from M must be resolved whenever a write is strobed
   assert property (@(posedge clk) we |-> !$isunknown(wa));

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsDefines.svh"

module alu
   import mipsPkg::*;
(
   input  logic [`DATA_WIDTH-1:0] a,
   input  logic [`DATA_WIDTH-1:0] b,
   input  aluOpT                  op,
   output logic [`DATA_WIDTH-1:0] result
);

   logic lessSigned;
   logic lessUnsigned;

   assign lessSigned   = $signed(a) < $signed(b);
   assign lessUnsigned = a < b;

   always_comb begin
      case (op)
         aluSub:  result = a - b;
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         aluXor:  result = a ^ b;
         aluNor:  result = ~(a | b);
         // Set-less-than yields 0 or 1
         aluSlt:  result = {{(`DATA_WIDTH-1){1'b0}}, lessSigned};
         aluSltu: result = {{(`DATA_WIDTH-1){1'b0}}, lessUnsigned};
         // Immediate moves into the upper half
         aluLui:  result = {b[15:0], 16'b0};
         default: result = a + b;
      endcase
   end

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsDefines.svh"

module fetchStage
   import mipsPkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       stall,
   input  logic [`DATA_WIDTH-1:0]     instr,
   output logic [`DATA_WIDTH-1:0]     fetchAddr,
   output opcodeT                     opcodeF,
   output functT                      functF,
   // Decoder levels for the word in F
   input  logic                       memToReg, regWrite, extType, aluSrc, regDst,
   input  aluOpT                      aluOp,
   input  logic                       jump, jr, jal, jalr,
   // Redirects resolved in E
   input  logic                       branchTaken,
   input  logic                       regJumpE,
   input  logic [`DATA_WIDTH-1:0]     regTarget,
   // Write port from M
   input  logic                       we,
   input  logic [`REG_ADDR_WIDTH-1:0] wa,
   input  logic [`DATA_WIDTH-1:0]     wd,
   // F/E register
   output logic [`DATA_WIDTH-1:0]     pcE,
   output opcodeT                     opcodeE,
   output logic [`REG_ADDR_WIDTH-1:0] rsE, rtE, rdE,
   output logic [`DATA_WIDTH-1:0]     rd1E, rd2E, immE,
   output logic                       memToRegE, regWriteE, aluSrcE, regDstE,
   output aluOpT                      aluOpE,
   output logic                       jumpE, jrE, jalE, jalrE
);

   logic [`DATA_WIDTH-1:0] pc;
   logic [`DATA_WIDTH-1:0] nextPc;
   logic [`DATA_WIDTH-1:0] immF;
   logic [`DATA_WIDTH-1:0] rd1F;
   logic [`DATA_WIDTH-1:0] rd2F;
   logic [25:0]            targetE;

   // Field split
   assign opcodeF = opcodeT'(instr[31:26]);
   assign functF  = functT'(instr[5:0]);
   assign immF    = extType ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

   regFile regs (
      .clk(clk),
      .ra1(instr[25:21]),
      .ra2(instr[20:16]),
      .we (we),
      .wa (wa),
      .wd (wd),
      .rd1(rd1F),
      .rd2(rd2F)
   );

   // Redirect priority is branch then jump then register jump
   always_comb begin
      if (branchTaken) begin
         nextPc = pcE + `PC_STEP + {immE[`DATA_WIDTH-3:0], 2'b00};
      end else if (jumpE) begin
         // Region bits come from the delay slot PC
         nextPc = {pc[`DATA_WIDTH-1:`DATA_WIDTH-4], targetE, 2'b00};
      end else if (regJumpE) begin
         nextPc = regTarget;
      end else begin
         nextPc = pc + `PC_STEP;
      end
   end

   // Stall refetches the word now in F
   assign fetchAddr = reset ? '0 : (stall ? pc : nextPc);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (!stall) begin
         pc <= nextPc;
      end
   end

   // F/E register
   // Reset wins over stall and loads a bubble
   always_ff @(posedge clk) begin
      if (reset || !stall) begin
         pcE       <= reset ? '0 : pc;
         opcodeE   <= reset ? opSpecial : opcodeF;
         rsE       <= reset ? '0 : instr[25:21];
         rtE       <= reset ? '0 : instr[20:16];
         rdE       <= reset ? '0 : instr[15:11];
         rd1E      <= reset ? '0 : rd1F;
         rd2E      <= reset ? '0 : rd2F;
         immE      <= reset ? '0 : immF;
         targetE   <= reset ? '0 : instr[25:0];
         memToRegE <= reset ? 1'b0 : memToReg;
         regWriteE <= reset ? 1'b0 : regWrite;
         aluSrcE   <= reset ? 1'b0 : aluSrc;
         regDstE   <= reset ? 1'b0 : regDst;
         aluOpE    <= reset ? aluAdd : aluOp;
         jumpE     <= reset ? 1'b0 : jump;
         jrE       <= reset ? 1'b0 : jr;
         jalE      <= reset ? 1'b0 : jal;
         jalrE     <= reset ? 1'b0 : jalr;
      end
   end

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsDefines.svh"

module executeStage
   import mipsPkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       stall,
   // From the F/E register
   input  logic [`DATA_WIDTH-1:0]     pcE,
   input  opcodeT                     opcodeE,
   input  logic [`REG_ADDR_WIDTH-1:0] rsE, rtE, rdE,
   input  logic [`DATA_WIDTH-1:0]     rd1E, rd2E, immE,
   input  logic                       memToRegE, regWriteE, aluSrcE, regDstE,
   input  aluOpT                      aluOpE,
   input  logic                       jumpE, jrE, jalE, jalrE,
   // Result leaving M
   input  logic [`DATA_WIDTH-1:0]     wbData,
   output logic                       branchTaken,
   output logic                       regJumpE,
   output logic [`DATA_WIDTH-1:0]     regTarget,
   output logic [`DATA_WIDTH-1:0]     aluOutE,
   output logic [`DATA_WIDTH-1:0]     storeDataE,
   // E/M register
   output logic [`DATA_WIDTH-1:0]     aluOutM,
   output opcodeT                     opcodeM,
   output logic [`REG_ADDR_WIDTH-1:0] waM,
   output logic                       regWriteM, memToRegM, linkM, jalM,
   output logic [`DATA_WIDTH-1:0]     pcM
);

   logic                       fwdA;
   logic                       fwdB;
   logic [`DATA_WIDTH-1:0]     srcA;
   logic [`DATA_WIDTH-1:0]     srcB;
   logic [`REG_ADDR_WIDTH-1:0] waE;

   // M-to-E forwarding
   // Register 0 never forwards
   assign fwdA = regWriteM && (waM != '0) && (waM == rsE);
   assign fwdB = regWriteM && (waM != '0) && (waM == rtE);
   assign srcA = fwdA ? wbData : rd1E;
   assign srcB = fwdB ? wbData : rd2E;

   assign storeDataE = srcB;
   assign regTarget  = srcA;
   assign regJumpE   = jrE || jalrE;

   alu aluUnit (
      .a     (srcA),
      .b     (aluSrcE ? immE : srcB),
      .op    (aluOpE),
      .result(aluOutE)
   );

   // Branch compare on forwarded operands
   always_comb begin
      case (opcodeE)
         opBeq:   branchTaken = (srcA == srcB);
         opBne:   branchTaken = (srcA != srcB);
         opBlez:  branchTaken = srcA[`DATA_WIDTH-1] || (srcA == '0);
         opBgtz:  branchTaken = !srcA[`DATA_WIDTH-1] && (srcA != '0);
         default: branchTaken = 1'b0;
      endcase
   end

   // Destination is r31 for jal, rd for R-type and jalr, else rt
   assign waE = jalE ? `LINK_REG : (regDstE ? rdE : rtE);

   // E/M register
   always_ff @(posedge clk) begin
      if (reset || !stall) begin
         aluOutM   <= reset ? '0 : aluOutE;
         opcodeM   <= reset ? opSpecial : opcodeE;
         waM       <= reset ? '0 : waE;
         regWriteM <= reset ? 1'b0 : regWriteE;
         memToRegM <= reset ? 1'b0 : memToRegE;
         linkM     <= reset ? 1'b0 : (jalE || jalrE);
         jalM      <= reset ? 1'b0 : jalE;
         pcM       <= reset ? '0 : pcE;
      end
   end

   // Jump flag from the F/E register never coincides with a local redirect
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({branchTaken, jumpE, regJumpE}));

endmodule

`default_nettype wire

/* memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsDefines.svh"

module memoryStage
   import mipsPkg::*;
(
   input  logic                       clk,
   input  logic                       stall,
   // Store and load address in E
   input  logic [`DATA_WIDTH-1:0]     aluOutE,
   input  logic [`DATA_WIDTH-1:0]     storeDataE,
   input  opcodeT                     opcodeE,
   // From the E/M register
   input  logic [`DATA_WIDTH-1:0]     aluOutM,
   input  opcodeT                     opcodeM,
   input  logic [`REG_ADDR_WIDTH-1:0] waM,
   input  logic                       regWriteM, memToRegM, linkM, jalM,
   input  logic [`DATA_WIDTH-1:0]     pcM,
   output logic [`DATA_WIDTH-1:0]     wbData,
   output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
   output logic                       wbValid
);

   logic [`DATA_WIDTH-1:0]      ram [0:(1 << `DMEM_ADDR_WIDTH)-1];
   logic [`DMEM_ADDR_WIDTH-1:0] ramAddr;
   logic [3:0]                  byteEn;
   logic [`DATA_WIDTH-1:0]      storeWord;
   logic [`DATA_WIDTH-1:0]      readWord;
   logic [`DATA_WIDTH-1:0]      loadData;
   logic [7:0]                  loadByte;
   logic [15:0]                 loadHalf;

   assign ramAddr = aluOutE[`DMEM_ADDR_WIDTH+1:2];

   // Lane enables
   // Narrow stores are replicated across lanes
   always_comb begin
      storeWord = storeDataE;
      case (opcodeE)
         opSb: begin
            byteEn    = 4'b0001 << aluOutE[1:0];
            storeWord = {4{storeDataE[7:0]}};
         end
         opSh: begin
            byteEn    = aluOutE[1] ? 4'b1100 : 4'b0011;
            storeWord = {2{storeDataE[15:0]}};
         end
         opSw:    byteEn = 4'b1111;
         default: byteEn = 4'b0000;
      endcase
   end

   // Write and read both happen at the edge ending E
   always_ff @(posedge clk) begin
      if (!stall) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (byteEn[lane]) begin
               ram[ramAddr][8*lane +: 8] <= storeWord[8*lane +: 8];
            end
         end
         readWord <= ram[ramAddr];
      end
   end

   // Load extract by byte offset
   assign loadByte = readWord[8*aluOutM[1:0] +: 8];
   assign loadHalf = aluOutM[1] ? readWord[31:16] : readWord[15:0];

   always_comb begin
      case (opcodeM)
         opLb:    loadData = {{24{loadByte[7]}}, loadByte};
         opLbu:   loadData = {24'b0, loadByte};
         opLh:    loadData = {{16{loadHalf[15]}}, loadHalf};
         opLhu:   loadData = {16'b0, loadHalf};
         default: loadData = readWord;
      endcase
   end

   // Link value first, then load data, then ALU result
   assign wbData  = linkM ? (pcM + `LINK_OFFSET) : (memToRegM ? loadData : aluOutM);
   assign wbAddr  = waM;
   assign wbValid = regWriteM && !stall;

   // Legal lane pattern on a naturally aligned address
   assert property (@(posedge clk) !stall && (|byteEn) |->
      (byteEn inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
      && ((opcodeE != opSh) || !aluOutE[0])
      && ((opcodeE != opSw) || (aluOutE[1:0] == 2'b00)));

endmodule

`default_nettype wire

/* mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsDefines.svh"

module mipsCore
   import mipsPkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       stall,
   input  logic [`DATA_WIDTH-1:0]     instr,
   output logic [`DATA_WIDTH-1:0]     fetchAddr,
   output logic                       wbValid,
   output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
   output logic [`DATA_WIDTH-1:0]     wbData
);

   // Decode in F
   opcodeT                     opcodeF;
   functT                      functF;
   logic                       memToReg, regWrite, extType, aluSrc, regDst;
   logic                       jump, jr, jal, jalr;
   aluOpT                      aluOp;

   // F/E register
   logic [`DATA_WIDTH-1:0]     pcE, rd1E, rd2E, immE;
   opcodeT                     opcodeE;
   logic [`REG_ADDR_WIDTH-1:0] rsE, rtE, rdE;
   logic                       memToRegE, regWriteE, aluSrcE, regDstE;
   logic                       jumpE, jrE, jalE, jalrE;
   aluOpT                      aluOpE;

   // Resolved in E
   logic                       branchTaken;
   logic                       regJumpE;
   logic [`DATA_WIDTH-1:0]     regTarget, aluOutE, storeDataE;

   // E/M register
   logic [`DATA_WIDTH-1:0]     aluOutM, pcM;
   opcodeT                     opcodeM;
   logic [`REG_ADDR_WIDTH-1:0] waM;
   logic                       regWriteM, memToRegM, linkM, jalM;

   controlDecoder decoder (
      .opcode(opcodeF),
      .funct (functF),
      .*
   );

   // Register file write comes from the M write-back
   fetchStage fetch (
      .we(wbValid),
      .wa(wbAddr),
      .wd(wbData),
      .*
   );

   executeStage execute (.*);

   memoryStage memStage (.*);

endmodule

`default_nettype wire

/* tbMipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore
   import mipsPkg::*;
();

   localparam int ResetCycles = 4;
   localparam int RomDepth    = 64;
   // Quiet cycles after the last write-back, catches stray writes
   localparam int DrainCycles = 12;

   logic        clk   = 1'b0;
   logic        reset = 1'b1;
   logic        stall = 1'b0;
   logic [31:0] instr = '0;
   logic [31:0] fetchAddr;
   logic        wbValid;
   logic [4:0]  wbAddr;
   logic [31:0] wbData;

   // Program table, one entry per word
   logic [31:0] progWord  [$];
   logic [4:0]  progReg   [$];
   logic [31:0] progValue [$];
   logic [31:0] rom [0:RomDepth-1];

   // Expected write-backs in program order
   logic [4:0]  expAddr [$];
   logic [31:0] expData [$];

   logic [31:0] fetchSampled = '0;
   int          cycleCount   = 0;
   bit          tableReady   = 1'b0;

   mipsCore uut (
      .clk      (clk),
      .reset    (reset),
      .stall    (stall),
      .instr    (instr),
      .fetchAddr(fetchAddr),
      .wbValid  (wbValid),
      .wbAddr   (wbAddr),
      .wbData   (wbData)
   );

   initial begin
      forever #50 clk = ~clk;
   end

   // Instruction word encoders
   function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] funct);
      return {6'h00, rs, rt, rd, 5'h00, funct};
   endfunction

   function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
      return {op, target};
   endfunction

   // Register 0 as destination means no write-back expected
   task automatic addStep(input logic [31:0] word, input logic [4:0] destReg,
                          input logic [31:0] value);
      progWord.push_back(word);
      progReg.push_back(destReg);
      progValue.push_back(value);
   endtask

   task automatic buildProgram();
      // ALU immediates, sign and zero extension
      addStep(encodeI(opAddiu, 5'd0, 5'd1, 16'h0005), 5'd1, 32'h0000_0005);
      addStep(encodeI(opAddiu, 5'd0, 5'd2, 16'hfffd), 5'd2, 32'hffff_fffd);
      // r2 through M-to-E, r1 through decode write-through
      addStep(encodeR(5'd1, 5'd2, 5'd3, fnAddu), 5'd3, 32'h0000_0002);
      addStep(encodeR(5'd1, 5'd2, 5'd4, fnSubu), 5'd4, 32'h0000_0008);
      addStep(encodeI(opOri, 5'd0, 5'd5, 16'h8001), 5'd5, 32'h0000_8001);
      addStep(encodeI(opAndi, 5'd2, 5'd6, 16'hff0f), 5'd6, 32'h0000_ff0d);
      addStep(encodeI(opXori, 5'd5, 5'd7, 16'hffff), 5'd7, 32'h0000_7ffe);
      addStep(encodeI(opLui, 5'd0, 5'd8, 16'h1234), 5'd8, 32'h1234_0000);
      addStep(encodeI(opOri, 5'd8, 5'd8, 16'h5678), 5'd8, 32'h1234_5678);
      addStep(encodeI(opSlti, 5'd2, 5'd9, 16'h0001), 5'd9, 32'h0000_0001);
      addStep(encodeI(opSltiu, 5'd2, 5'd10, 16'h0001), 5'd10, 32'h0000_0000);
      // Register ALU operations
      addStep(encodeR(5'd2, 5'd1, 5'd11, fnSlt), 5'd11, 32'h0000_0001);
      addStep(encodeR(5'd2, 5'd1, 5'd12, fnSltu), 5'd12, 32'h0000_0000);
      addStep(encodeR(5'd8, 5'd6, 5'd13, fnAnd), 5'd13, 32'h0000_5608);
      addStep(encodeR(5'd5, 5'd8, 5'd14, fnOr), 5'd14, 32'h1234_d679);
      addStep(encodeR(5'd8, 5'd2, 5'd15, fnXor), 5'd15, 32'hedcb_a985);
      addStep(encodeR(5'd1, 5'd4, 5'd16, fnNor), 5'd16, 32'hffff_fff2);
      // Data memory base 0x100
      addStep(encodeI(opAddiu, 5'd0, 5'd20, 16'h0100), 5'd20, 32'h0000_0100);
      addStep(encodeI(opSw, 5'd20, 5'd8, 16'h0000), 5'd0, 32'h0);
      addStep(encodeI(opSb, 5'd20, 5'd16, 16'h0001), 5'd0, 32'h0);
      addStep(encodeI(opSh, 5'd20, 5'd2, 16'h0002), 5'd0, 32'h0);
      // Word now reads 0xfffdf278
      addStep(encodeI(opLw, 5'd20, 5'd17, 16'h0000), 5'd17, 32'hfffd_f278);
      // Load followed directly by its use
      addStep(encodeR(5'd17, 5'd1, 5'd18, fnAddu), 5'd18, 32'hfffd_f27d);
      addStep(encodeI(opLb, 5'd20, 5'd19, 16'h0001), 5'd19, 32'hffff_fff2);
      addStep(encodeI(opLbu, 5'd20, 5'd21, 16'h0001), 5'd21, 32'h0000_00f2);
      addStep(encodeI(opLh, 5'd20, 5'd22, 16'h0002), 5'd22, 32'hffff_fffd);
      addStep(encodeI(opLhu, 5'd20, 5'd23, 16'h0002), 5'd23, 32'h0000_fffd);
      addStep(encodeI(opLb, 5'd20, 5'd24, 16'h0000), 5'd24, 32'h0000_0078);
      addStep(encodeI(opLh, 5'd20, 5'd25, 16'h0000), 5'd25, 32'hffff_f278);
      // Word 29, taken beq to word 32
      addStep(encodeI(opBeq, 5'd1, 5'd1, 16'h0002), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd0, 5'd26, 16'h0011), 5'd26, 32'h0000_0011);
      // Skipped
      addStep(encodeI(opAddiu, 5'd0, 5'd26, 16'h0bad), 5'd0, 32'h0);
      // Not taken
      addStep(encodeI(opBne, 5'd1, 5'd1, 16'h0005), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd0, 5'd27, 16'h0022), 5'd27, 32'h0000_0022);
      // Word 34, taken bne to word 37
      addStep(encodeI(opBne, 5'd1, 5'd2, 16'h0002), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd26, 5'd28, 16'h0001), 5'd28, 32'h0000_0012);
      addStep(encodeI(opAddiu, 5'd0, 5'd28, 16'h0bad), 5'd0, 32'h0);
      // 0x12 against 0x11, falls through
      addStep(encodeI(opBeq, 5'd28, 5'd26, 16'h0002), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd0, 5'd29, 16'h0033), 5'd29, 32'h0000_0033);
      // Word 39, j to word 42
      addStep(encodeJ(opJ, 26'd42), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd0, 5'd30, 16'h0044), 5'd30, 32'h0000_0044);
      addStep(encodeI(opAddiu, 5'd0, 5'd30, 16'h0bad), 5'd0, 32'h0);
      // Word 42, jal to word 45, link 42*4+8
      addStep(encodeJ(opJal, 26'd45), 5'd31, 32'h0000_00b0);
      addStep(encodeI(opAddiu, 5'd0, 5'd3, 16'h0055), 5'd3, 32'h0000_0055);
      addStep(encodeI(opAddiu, 5'd0, 5'd3, 16'h0bad), 5'd0, 32'h0);
      // jr through forwarded r4 to word 49
      addStep(encodeI(opAddiu, 5'd0, 5'd4, 16'h00c4), 5'd4, 32'h0000_00c4);
      addStep(encodeR(5'd4, 5'd0, 5'd0, fnJr), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd0, 5'd5, 16'h0066), 5'd5, 32'h0000_0066);
      addStep(encodeI(opAddiu, 5'd0, 5'd5, 16'h0bad), 5'd0, 32'h0);
      // Word 50, jalr r7 to word 54, link 50*4+8
      addStep(encodeI(opAddiu, 5'd0, 5'd6, 16'h00d8), 5'd6, 32'h0000_00d8);
      addStep(encodeR(5'd6, 5'd0, 5'd7, fnJalr), 5'd7, 32'h0000_00d0);
      // Delay slot uses the link value
      addStep(encodeI(opAddiu, 5'd7, 5'd9, 16'h0001), 5'd9, 32'h0000_00d1);
      addStep(encodeI(opAddiu, 5'd0, 5'd9, 16'h0bad), 5'd0, 32'h0);
      addStep(encodeI(opAddiu, 5'd0, 5'd9, 16'h0bad), 5'd0, 32'h0);
      addStep(encodeR(5'd31, 5'd7, 5'd10, fnAddu), 5'd10, 32'h0000_0180);
      // Park in a jump-to-self with a nop slot
      addStep(encodeJ(opJ, 26'd55), 5'd0, 32'h0);
      addStep(32'h0000_0000, 5'd0, 32'h0);
   endtask

   // Table into ROM, writers into the expected queue
   task automatic loadTable();
      for (int i = 0; i < RomDepth; i++) begin
         if (i < progWord.size()) begin
            rom[i] = progWord[i];
            if (progReg[i] != 5'd0) begin
               expAddr.push_back(progReg[i]);
               expData.push_back(progValue[i]);
            end
         end else begin
            rom[i] = '0;
         end
      end
   endtask

   function automatic logic [31:0] romWord(input logic [31:0] addr);
      // Past the ROM reads as nop
      if ((addr >> 2) < 32'(RomDepth)) begin
         return rom[addr[7:2]];
      end
      return '0;
   endfunction

   task automatic stopOnError();
      $display("Verification failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
         stopOnError();
      end
   endtask

   // ROM address taken at the rising edge
   always @(posedge clk) begin
      fetchSampled <= fetchAddr;
      cycleCount   <= cycleCount + 1;
   end

   // Inputs change on the falling edge
   always @(negedge clk) begin
      instr <= romWord(fetchSampled);
      reset <= (cycleCount < ResetCycles);
      // Stall about one cycle in four once out of reset
      stall <= (cycleCount >= ResetCycles) && (($urandom % 4) == 0);
   end

   // Write-back checker
   always @(posedge clk) begin
      if (reset) begin
         // Fetch is pinned to word 0 during reset
         checkValue("fetchAddr", fetchAddr, 32'h0);
      end else if ($isunknown(wbValid)) begin
         $display("Write-back valid is unknown after reset");
         stopOnError();
      end else if (wbValid) begin
         if (expData.size() == 0) begin
            $display("Register write-back to r%0d with no write-back left to expect", wbAddr);
            stopOnError();
         end else begin
            checkValue("wbAddr", 32'(wbAddr), 32'(expAddr.pop_front()));
            checkValue("wbData", wbData, expData.pop_front());
         end
      end
   end

   // Watchdog scaled to the table length
   initial begin
      wait (tableReady);
      repeat (progWord.size() * 8 + 20) @(posedge clk);
      $display("Timeout with %0d write-backs still outstanding", expData.size());
      stopOnError();
   end

   initial begin
      void'($urandom(32'h6039));
      buildProgram();
      loadTable();
      tableReady = 1'b1;
      while (expData.size() != 0) begin
         @(negedge clk);
      end
      // Jump-to-self loop must stay silent
      repeat (DrainCycles) @(negedge clk);
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
mipsPkg.sv
controlDecoder.sv
regFile.sv
alu.sv
fetchStage.sv
executeStage.sv
memoryStage.sv
mipsCore.sv
tbMipsCore.sv

/* run.sh */
#!/bin/sh
# Build the core and testbench with Verilator, run, then search the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tbMipsCore -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VtbMipsCore > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
